// ==== verilog/tm_pkg.sv ====
// NUM_BUFS must be a power of two and THRESH_W has room for the largest left shift of alpha
`default_nettype none

package tm_pkg;

	// ========================================================================
	// sizes
	localparam int NUM_QUEUES = 16;
	localparam int QID_W      = 4;
	localparam int NUM_BUFS   = 32;
	localparam int BUF_W      = 5;
	localparam int CNT_W      = 6;           // holds NUM_BUFS itself
	localparam int DESC_W     = 16;
	localparam int ALPHA_W    = 4;
	localparam int THRESH_W   = CNT_W + 7;   // free count << 7
	localparam int DROP_W     = 16;

	// ========================================================================
	// command opcodes
	typedef enum logic {
		OP_ENQ = 1'b0,
		OP_DEQ = 1'b1
	} tm_op_e;

	// ========================================================================
	// apb register map
	localparam int APB_AW = 4;
	localparam int APB_DW = 32;

	localparam logic [APB_AW-1:0] REG_ALPHA  = 4'h0;  // rw, bit 3 selects right shift
	localparam logic [APB_AW-1:0] REG_THRESH = 4'h4;  // ro
	localparam logic [APB_AW-1:0] REG_FREE   = 4'h8;  // ro
	localparam logic [APB_AW-1:0] REG_DROPS  = 4'hC;  // ro, write clears

endpackage

`default_nettype wire

// ==== verilog/tm_ram_1r1w.sv ====
// registered read with no reset and a read of an address written in the same cycle sees the old word
`default_nettype none
`timescale 1ns/1ns

module tm_ram_1r1w #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  wire                     clk,
	input  wire                     wr,
	input  wire [$clog2(DEPTH)-1:0] waddr,
	input  wire [WIDTH-1:0]         din,
	input  wire [$clog2(DEPTH)-1:0] raddr,
	output logic [WIDTH-1:0]        dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr];  // old data on collision
	end

endmodule

`default_nettype wire

// ==== verilog/tm_freeq.sv ====
// free list is only usable once fill_busy drops, NUM_BUFS cycles after reset, and pops when empty are ignored
`default_nettype none
`timescale 1ns/1ns

module tm_freeq (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      alloc,
	input  wire                      release_vld,
	input  wire [tm_pkg::BUF_W-1:0]  release_idx,
	output logic [tm_pkg::BUF_W-1:0] free_head,
	output logic [tm_pkg::CNT_W-1:0] free_count,
	output logic                     free_empty,
	output logic                     fill_busy
);

	import tm_pkg::*;

	logic [BUF_W-1:0] ring [NUM_BUFS];
	logic [BUF_W-1:0] rd_ptr;
	logic [BUF_W-1:0] wr_ptr;
	logic [BUF_W-1:0] fill_idx;
	logic             push;
	logic             pop;

	assign push       = fill_busy | release_vld;
	assign pop        = alloc & ~free_empty;
	assign free_head  = ring[rd_ptr];      // valid in the cycle it is popped
	assign free_empty = (free_count == '0);

	// ========================================================================
	// ring storage
	always_ff @(posedge clk) begin
		if (push) begin
			ring[wr_ptr] <= fill_busy ? fill_idx : release_idx;
		end
	end

	// ========================================================================
	// pointers, fill sequence and count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr     <= '0;
			wr_ptr     <= '0;
			fill_idx   <= '0;
			fill_busy  <= 1'b1;
			free_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps, pool is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (fill_busy) begin
				fill_idx <= fill_idx + 1'b1;
				if (fill_idx == BUF_W'(NUM_BUFS - 1)) begin
					fill_busy <= 1'b0;
				end
			end
			free_count <= free_count + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tm_queue_depth.sv ====
// one update per cycle and the caller keeps each depth within 0 to NUM_BUFS
`default_nettype none
`timescale 1ns/1ns

module tm_queue_depth (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      inc,
	input  wire                      dec,
	input  wire [tm_pkg::QID_W-1:0]  upd_qid,
	input  wire [tm_pkg::QID_W-1:0]  rd_qid,
	output logic [tm_pkg::CNT_W-1:0] depth
);

	import tm_pkg::*;

	logic [CNT_W-1:0] qlen [NUM_QUEUES];

	assign depth = qlen[rd_qid];  // combinational, used at acceptance

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_QUEUES; i++) begin
				qlen[i] <= '0;
			end
		end else if (inc != dec) begin
			if (inc) begin
				qlen[upd_qid] <= qlen[upd_qid] + 1'b1;
			end else begin
				qlen[upd_qid] <= qlen[upd_qid] - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tm_linked_list.sv ====
// commands are serialized and a command waits while its queue has one in the last three stages
`default_nettype none
`timescale 1ns/1ns

module tm_linked_list (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         cmd_valid,
	output logic                        cmd_ready,
	input  wire tm_pkg::tm_op_e         cmd_op,
	input  wire [tm_pkg::QID_W-1:0]     cmd_qid,
	input  wire [tm_pkg::DESC_W-1:0]    cmd_desc,
	input  wire [tm_pkg::THRESH_W-1:0]  queue_threshold,
	input  wire [tm_pkg::BUF_W-1:0]     free_head,
	input  wire                         free_empty,
	input  wire                         fill_busy,
	input  wire [tm_pkg::CNT_W-1:0]     depth,
	output logic                        enq_done,
	output logic                        enq_drop,
	output logic                        deq_valid,
	output logic                        deq_empty,
	output logic [tm_pkg::QID_W-1:0]    deq_qid,
	output logic [tm_pkg::DESC_W-1:0]   deq_desc,
	output logic                        alloc,
	output logic                        release_vld,
	output logic [tm_pkg::BUF_W-1:0]    release_idx,
	output logic [tm_pkg::QID_W-1:0]    rd_qid,
	output logic                        inc,
	output logic                        dec,
	output logic [tm_pkg::QID_W-1:0]    upd_qid
);

	import tm_pkg::*;

	// in-flight tracker, entry 0 holds last cycle's command
	logic [2:0]        fl_vld;
	logic [QID_W-1:0]  fl_qid [3];

	logic              hazard;
	logic              accept;
	logic              acc_enq;
	logic              acc_deq;
	logic              admit;
	logic              enq_ok;

	logic              s1_deq;
	logic              s1_empty;
	logic              s1_link;
	logic              s1_first;
	logic [BUF_W-1:0]  s1_buf;
	logic              s2_deq;
	logic              s2_empty;
	logic              s2_first;
	logic [BUF_W-1:0]  s2_buf;

	logic              head_wr;
	logic [BUF_W-1:0]  head_wdata;
	logic [BUF_W-1:0]  head_rdata;
	logic [BUF_W-1:0]  head_wdata_d1;
	logic              head_byp;
	logic [BUF_W-1:0]  mhead;
	logic [BUF_W-1:0]  tail_rdata;
	logic [BUF_W-1:0]  next_rdata;
	logic [DESC_W-1:0] desc_rdata;

	// ========================================================================
	// acceptance and admission
	assign hazard = (fl_vld[0] && fl_qid[0] == cmd_qid) ||
	                (fl_vld[1] && fl_qid[1] == cmd_qid) ||
	                (fl_vld[2] && fl_qid[2] == cmd_qid);

	assign cmd_ready = ~fill_busy & ~hazard;
	assign accept    = cmd_valid & cmd_ready;
	assign acc_enq   = accept & (cmd_op == OP_ENQ);
	assign acc_deq   = accept & (cmd_op == OP_DEQ);

	assign rd_qid  = cmd_qid;
	assign admit   = ~free_empty & (THRESH_W'(depth) < queue_threshold);
	assign enq_ok  = acc_enq & admit;
	assign alloc   = enq_ok;
	assign inc     = enq_ok;
	assign dec     = acc_deq & (depth != '0);  // empty dequeue leaves depth alone
	assign upd_qid = cmd_qid;

	// stage 2 side
	assign release_vld = s2_deq & ~s2_empty;
	assign release_idx = s2_buf;
	assign head_wr     = release_vld | s2_first;
	assign head_wdata  = s2_deq ? next_rdata : s2_buf;
	assign mhead       = head_byp ? head_wdata_d1 : head_rdata;
	assign deq_qid     = fl_qid[2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fl_vld    <= '0;
			s1_deq    <= 1'b0;
			s1_link   <= 1'b0;
			s1_first  <= 1'b0;
			s2_deq    <= 1'b0;
			s2_first  <= 1'b0;
			head_byp  <= 1'b0;
			enq_done  <= 1'b0;
			enq_drop  <= 1'b0;
			deq_valid <= 1'b0;
		end else begin
			fl_vld    <= {fl_vld[1:0], accept};
			s1_deq    <= acc_deq;
			s1_link   <= enq_ok & (depth != '0);
			s1_first  <= enq_ok & (depth == '0);
			s2_deq    <= s1_deq;
			s2_first  <= s1_first;
			head_byp  <= head_wr & (fl_qid[1] == cmd_qid);
			enq_done  <= enq_ok;
			enq_drop  <= acc_enq & ~admit;
			deq_valid <= s2_deq;
		end
	end

	always_ff @(posedge clk) begin
		fl_qid[0]     <= cmd_qid;
		fl_qid[1]     <= fl_qid[0];
		fl_qid[2]     <= fl_qid[1];
		s1_empty      <= (depth == '0);
		s1_buf        <= free_head;
		s2_empty      <= s1_empty;
		s2_buf        <= s1_deq ? mhead : s1_buf;  // old head or new buffer
		head_wdata_d1 <= head_wdata;
		deq_empty     <= s2_empty;
		deq_desc      <= s2_empty ? '0 : desc_rdata;
	end

	// ========================================================================
	// pointer and descriptor memories
	tm_ram_1r1w #(.WIDTH(BUF_W), .DEPTH(NUM_QUEUES)) u_head_ram (
		.clk   (clk),
		.wr    (head_wr),
		.waddr (fl_qid[1]),
		.din   (head_wdata),
		.raddr (cmd_qid),
		.dout  (head_rdata)
	);

	// written at acceptance, read returns the previous tail
	tm_ram_1r1w #(.WIDTH(BUF_W), .DEPTH(NUM_QUEUES)) u_tail_ram (
		.clk   (clk),
		.wr    (enq_ok),
		.waddr (cmd_qid),
		.din   (free_head),
		.raddr (cmd_qid),
		.dout  (tail_rdata)
	);

	tm_ram_1r1w #(.WIDTH(BUF_W), .DEPTH(NUM_BUFS)) u_next_ram (
		.clk   (clk),
		.wr    (s1_link),
		.waddr (tail_rdata),    // old tail links to new buffer
		.din   (s1_buf),
		.raddr (mhead),
		.dout  (next_rdata)
	);

	tm_ram_1r1w #(.WIDTH(DESC_W), .DEPTH(NUM_BUFS)) u_desc_ram (
		.clk   (clk),
		.wr    (enq_ok),
		.waddr (free_head),
		.din   (cmd_desc),
		.raddr (mhead),
		.dout  (desc_rdata)
	);

endmodule

`default_nettype wire

// ==== verilog/tm_apb_regs.sv ====
// no wait states and read data is captured in the setup phase
`default_nettype none
`timescale 1ns/1ns

module tm_apb_regs (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  wire [tm_pkg::APB_AW-1:0]    paddr,
	input  wire [tm_pkg::APB_DW-1:0]    pwdata,
	input  wire [tm_pkg::CNT_W-1:0]     free_count,
	input  wire                         enq_drop,
	output logic [tm_pkg::APB_DW-1:0]   prdata,
	output logic                        pready,
	output logic                        pslverr,
	output logic [tm_pkg::THRESH_W-1:0] queue_threshold
);

	import tm_pkg::*;

	logic [ALPHA_W-1:0]  alpha;
	logic [DROP_W-1:0]   drops;
	logic [THRESH_W-1:0] free_ext;
	logic [APB_DW-1:0]   rd_mux;
	logic                setup;
	logic                wr_en;
	logic                mapped;

	assign pready   = 1'b1;
	assign setup    = psel & ~penable;
	assign wr_en    = psel & penable & pwrite;
	assign free_ext = THRESH_W'(free_count);

	always_comb begin
		mapped = 1'b1;
		case (paddr)
			REG_ALPHA:  rd_mux = APB_DW'(alpha);
			REG_THRESH: rd_mux = APB_DW'(queue_threshold);
			REG_FREE:   rd_mux = APB_DW'(free_count);
			REG_DROPS:  rd_mux = APB_DW'(drops);
			default: begin
				rd_mux = '0;
				mapped = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alpha           <= '0;  // threshold = free count
			drops           <= '0;
			queue_threshold <= '0;
			pslverr         <= 1'b0;
		end else begin
			if (wr_en && paddr == REG_ALPHA) begin
				alpha <= pwdata[ALPHA_W-1:0];
			end
			if (wr_en && paddr == REG_DROPS) begin
				drops <= '0;
			end else if (enq_drop && drops != '1) begin
				drops <= drops + 1'b1;  // saturates
			end
			queue_threshold <= alpha[3] ? free_ext >> alpha[2:0] : free_ext << alpha[2:0];
			pslverr         <= setup & ~mapped;
		end
	end

	always_ff @(posedge clk) begin
		if (setup) begin
			prdata <= rd_mux;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tm_queue_mgr.sv ====
// cmd_ready stays low for NUM_BUFS cycles after reset while the free list fills
`default_nettype none
`timescale 1ns/1ns

module tm_queue_mgr (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       cmd_valid,
	output logic                      cmd_ready,
	input  wire tm_pkg::tm_op_e       cmd_op,
	input  wire [tm_pkg::QID_W-1:0]   cmd_qid,
	input  wire [tm_pkg::DESC_W-1:0]  cmd_desc,
	output logic                      enq_done,
	output logic                      enq_drop,
	output logic                      deq_valid,
	output logic                      deq_empty,
	output logic [tm_pkg::QID_W-1:0]  deq_qid,
	output logic [tm_pkg::DESC_W-1:0] deq_desc,
	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire [tm_pkg::APB_AW-1:0]  paddr,
	input  wire [tm_pkg::APB_DW-1:0]  pwdata,
	output logic [tm_pkg::APB_DW-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr
);

	import tm_pkg::*;

	logic [BUF_W-1:0]    free_head;
	logic [CNT_W-1:0]    free_count;
	logic                free_empty;
	logic                fill_busy;
	logic                alloc;
	logic                release_vld;
	logic [BUF_W-1:0]    release_idx;
	logic [QID_W-1:0]    rd_qid;
	logic [QID_W-1:0]    upd_qid;
	logic [CNT_W-1:0]    depth;
	logic                inc;
	logic                dec;
	logic [THRESH_W-1:0] queue_threshold;

	tm_freeq u_freeq (
		.clk         (clk),
		.rst_n       (rst_n),
		.alloc       (alloc),
		.release_vld (release_vld),
		.release_idx (release_idx),
		.free_head   (free_head),
		.free_count  (free_count),
		.free_empty  (free_empty),
		.fill_busy   (fill_busy)
	);

	tm_queue_depth u_queue_depth (
		.clk     (clk),
		.rst_n   (rst_n),
		.inc     (inc),
		.dec     (dec),
		.upd_qid (upd_qid),
		.rd_qid  (rd_qid),
		.depth   (depth)
	);

	tm_linked_list u_linked_list (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd_valid       (cmd_valid),
		.cmd_ready       (cmd_ready),
		.cmd_op          (cmd_op),
		.cmd_qid         (cmd_qid),
		.cmd_desc        (cmd_desc),
		.queue_threshold (queue_threshold),
		.free_head       (free_head),
		.free_empty      (free_empty),
		.fill_busy       (fill_busy),
		.depth           (depth),
		.enq_done        (enq_done),
		.enq_drop        (enq_drop),
		.deq_valid       (deq_valid),
		.deq_empty       (deq_empty),
		.deq_qid         (deq_qid),
		.deq_desc        (deq_desc),
		.alloc           (alloc),
		.release_vld     (release_vld),
		.release_idx     (release_idx),
		.rd_qid          (rd_qid),
		.inc             (inc),
		.dec             (dec),
		.upd_qid         (upd_qid)
	);

	tm_apb_regs u_apb_regs (
		.clk             (clk),
		.rst_n           (rst_n),
		.psel            (psel),
		.penable         (penable),
		.pwrite          (pwrite),
		.paddr           (paddr),
		.pwdata          (pwdata),
		.free_count      (free_count),
		.enq_drop        (enq_drop),   // drop counter source
		.prdata          (prdata),
		.pready          (pready),
		.pslverr         (pslverr),
		.queue_threshold (queue_threshold)
	);

endmodule

`default_nettype wire

// ==== verif/tm_queue_mgr_properties.sv ====
// checks are sampled on the rising clock and all but the reset check are off while rst_n is low
`default_nettype none
`timescale 1ns/1ns

module tm_queue_mgr_properties (
	input wire                 clk,
	input wire                 rst_n,
	input wire                 cmd_valid,
	input wire                 cmd_ready,
	input wire tm_pkg::tm_op_e cmd_op,
	input wire                 enq_done,
	input wire                 enq_drop,
	input wire                 deq_valid
);

	import tm_pkg::*;

	// ========================================================================
	// result latency
	a_deq_latency: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && cmd_ready && cmd_op == OP_DEQ |-> ##3 deq_valid)
		else $error("dequeue response not seen 3 cycles after acceptance");

	a_enq_latency: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && cmd_ready && cmd_op == OP_ENQ |=> (enq_done || enq_drop))
		else $error("enqueue result not seen 1 cycle after acceptance");

	a_enq_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(enq_done && enq_drop))
		else $error("enq_done and enq_drop high together");

	// ready held off once reset has been sampled
	a_reset_ready: assert property (@(posedge clk) !rst_n |=> !cmd_ready)
		else $error("cmd_ready high during reset");

endmodule

`default_nettype wire

// ==== verif/tm_queue_mgr_tb.sv ====
// every task starts and ends on a rising edge, and results are compared at the falling edge
`default_nettype none
`timescale 1ns/1ns

module tm_queue_mgr_tb;

	import tm_pkg::*;

	localparam int TIMEOUT = 300;

	logic clk, rst_n, cmd_valid, cmd_ready, enq_done, enq_drop;
	logic deq_valid, deq_empty, psel, penable, pwrite, pready, pslverr;
	tm_op_e cmd_op;
	logic [QID_W-1:0] cmd_qid, deq_qid;
	logic [DESC_W-1:0] cmd_desc, deq_desc;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata, prdata;

	// reference model
	logic [DESC_W-1:0] ref_mem [NUM_QUEUES][NUM_BUFS];
	int ref_rd [NUM_QUEUES];
	int ref_cnt [NUM_QUEUES];
	int ref_free, drops_seen, drops_dut, errors, checks, errs_before;
	logic [3:0] ref_alpha;
	logic [31:0] rng;
	logic exp_enq [$];
	logic [DESC_W+QID_W:0] exp_deq [$];  // {empty, qid, desc}

	tm_queue_mgr u_dut (.*);

	bind tm_queue_mgr tm_queue_mgr_properties u_props (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int thresh_of(input int free, input logic [3:0] alpha);
		return alpha[3] ? (free >> alpha[2:0]) : (free << alpha[2:0]);
	endfunction

	// predicted drop
	function automatic logic ref_admit(input int depth, input int free, input logic [3:0] alpha);
		return (free == 0) || (depth >= thresh_of(free, alpha));
	endfunction

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		$display("test failed");
		$finish;
	endtask

	task automatic issue_cmd(input tm_op_e op, input logic [QID_W-1:0] qid,
			input logic [DESC_W-1:0] desc);
		int waited;
		logic drop;
		waited = 0;
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		cmd_qid   <= qid;
		cmd_desc  <= desc;
		@(negedge clk);
		while (!cmd_ready) begin
			waited++;
			if (waited > TIMEOUT) timed_out("cmd_ready");
			@(negedge clk);
		end
		@(posedge clk);  // accepted here
		if (op == OP_ENQ) begin
			drop = ref_admit(ref_cnt[qid], ref_free, ref_alpha);
			exp_enq.push_back(drop);
			if (drop) begin
				drops_seen++;
			end else begin
				ref_mem[qid][(ref_rd[qid] + ref_cnt[qid]) % NUM_BUFS] = desc;
				ref_cnt[qid]++;
				ref_free--;
			end
		end else if (ref_cnt[qid] == 0) begin
			exp_deq.push_back({1'b1, qid, {DESC_W{1'b0}}});
		end else begin
			exp_deq.push_back({1'b0, qid, ref_mem[qid][ref_rd[qid]]});
			ref_rd[qid] = (ref_rd[qid] + 1) % NUM_BUFS;
			ref_cnt[qid]--;
			ref_free++;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		cmd_valid <= 1'b0;
		@(negedge clk);
		while (exp_enq.size() != 0 || exp_deq.size() != 0) begin
			waited++;
			if (waited > TIMEOUT) timed_out("pending results");
			@(negedge clk);
		end
		repeat (3) @(posedge clk);  // free count and threshold settle
	endtask

	task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		if (!pready) begin
			$display("pready low during an access phase");
			errors++;
		end
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		logic [APB_DW-1:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
	endtask

	task automatic reg_check(input logic [APB_AW-1:0] addr, input int exp, input string name);
		logic [APB_DW-1:0] rd;
		logic err;
		apb_xfer(1'b0, addr, '0, rd, err);
		checks++;
		if (rd != APB_DW'(exp)) begin
			$display("Error: prdata (%s) got %h expected %h", name, rd, APB_DW'(exp));
			errors++;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - errs_before);
		errs_before = errors;
	endtask

	// ========================================================================
	// compare process
	initial begin
		logic e;
		logic [DESC_W+QID_W:0] d;
		forever begin
			@(negedge clk);
			if (rst_n && enq_drop) begin
				drops_dut++;
			end
			if (rst_n && (enq_done || enq_drop)) begin
				if (exp_enq.size() == 0) begin
					$display("enqueue result with no enqueue pending");
					errors++;
				end else begin
					e = exp_enq.pop_front();
					checks++;
					if (enq_drop !== e || enq_done !== ~e) begin
						$display("Error: enq_done/enq_drop got %h expected %h",
							{enq_done, enq_drop}, {~e, e});
						errors++;
					end
				end
			end
			if (rst_n && deq_valid) begin
				if (exp_deq.size() == 0) begin
					$display("dequeue response with no dequeue pending");
					errors++;
				end else begin
					d = exp_deq.pop_front();
					checks++;
					if ({deq_empty, deq_qid, deq_desc} !== d) begin
						$display("Error: deq_empty/deq_qid/deq_desc got %h expected %h",
							{deq_empty, deq_qid, deq_desc}, d);
						errors++;
					end
				end
			end
		end
	end

	// ========================================================================
	// stimulus
	initial begin
		int waited;
		logic [APB_DW-1:0] rd;
		logic err;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = OP_ENQ;
		cmd_qid = '0;
		cmd_desc = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rng = 32'hcdb5;
		ref_free = NUM_BUFS;
		ref_alpha = 4'h0;
		errors = 0;
		checks = 0;
		errs_before = 0;
		drops_seen = 0;
		drops_dut = 0;
		for (int q = 0; q < NUM_QUEUES; q++) begin
			ref_rd[q] = 0;
			ref_cnt[q] = 0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		waited = 0;
		@(negedge clk);
		while (!cmd_ready) begin
			waited++;
			if (waited > TIMEOUT) timed_out("cmd_ready after reset");
			@(negedge clk);
		end
		@(posedge clk);
		reg_check(REG_FREE, NUM_BUFS, "REG_FREE");
		finish_test(1, "reset and fill");

		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			issue_cmd(OP_ENQ, QID_W'(rng[1:0]), rng[31:16]);
		end
		for (int r = 0; r < 16; r++) begin
			for (int q = 0; q < 4; q++) begin
				if (ref_cnt[q] > 0) issue_cmd(OP_DEQ, QID_W'(q), '0);
			end
		end
		drain();
		reg_check(REG_FREE, NUM_BUFS, "REG_FREE");
		finish_test(2, "fifo order");

		issue_cmd(OP_DEQ, 4'd9, '0);
		issue_cmd(OP_DEQ, 4'd9, '0);  // depth must not have wrapped
		drain();
		reg_check(REG_FREE, ref_free, "REG_FREE");
		finish_test(3, "empty dequeue");

		apb_write(REG_DROPS, '0);
		drops_seen = 0;
		drops_dut = 0;
		ref_alpha = 4'h9;  // right shift by 1
		apb_write(REG_ALPHA, 32'h9);
		repeat (3) @(posedge clk);
		reg_check(REG_THRESH, thresh_of(ref_free, ref_alpha), "REG_THRESH");
		for (int i = 0; i < 14; i++) begin
			issue_cmd(OP_ENQ, 4'd3, DESC_W'(16'h3000 + i));
		end
		drain();
		checks++;
		if (drops_dut != drops_seen) begin
			$display("Error: enq_drop count got %h expected %h", drops_dut, drops_seen);
			errors++;
		end
		reg_check(REG_DROPS, drops_seen, "REG_DROPS");
		while (ref_cnt[3] > 0) issue_cmd(OP_DEQ, 4'd3, '0);
		drain();
		finish_test(4, "threshold drop");

		apb_write(REG_DROPS, '0);
		drops_seen = 0;
		drops_dut = 0;
		ref_alpha = 4'h1;
		apb_write(REG_ALPHA, 32'h1);
		repeat (3) @(posedge clk);
		for (int i = 0; i < NUM_BUFS + 1; i++) begin
			issue_cmd(OP_ENQ, QID_W'(i % NUM_QUEUES), DESC_W'(16'h5000 + i));
		end
		drain();
		checks++;
		if (drops_dut != 1) begin
			$display("Error: enq_drop count got %h expected %h", drops_dut, 1);
			errors++;
		end
		reg_check(REG_DROPS, 1, "REG_DROPS");
		for (int r = 0; r < 3; r++) begin
			for (int q = 0; q < NUM_QUEUES; q++) begin
				if (ref_cnt[q] > 0) issue_cmd(OP_DEQ, QID_W'(q), '0);
			end
		end
		drain();
		reg_check(REG_FREE, NUM_BUFS, "REG_FREE");
		finish_test(5, "pool exhaustion");

		ref_alpha = 4'h0;
		apb_write(REG_ALPHA, 32'h0);
		repeat (3) @(posedge clk);
		for (int i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			issue_cmd(rng[0] ? OP_DEQ : OP_ENQ, (i % 2) ? 4'd6 : 4'd5, rng[31:16]);
		end
		while (ref_cnt[5] > 0 || ref_cnt[6] > 0) begin
			if (ref_cnt[5] > 0) issue_cmd(OP_DEQ, 4'd5, '0);
			if (ref_cnt[6] > 0) issue_cmd(OP_DEQ, 4'd6, '0);
		end
		drain();
		reg_check(REG_FREE, NUM_BUFS, "REG_FREE");
		apb_xfer(1'b0, 4'h2, '0, rd, err);
		checks++;
		if (err !== 1'b1) begin
			$display("Error: pslverr got %h expected %h", err, 1'b1);
			errors++;
		end
		finish_test(6, "mixed commands");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tm_queue_mgr.f ====
verilog/tm_pkg.sv
verilog/tm_ram_1r1w.sv
verilog/tm_freeq.sv
verilog/tm_queue_depth.sv
verilog/tm_linked_list.sv
verilog/tm_apb_regs.sv
verilog/tm_queue_mgr.sv
verif/tm_queue_mgr_properties.sv
verif/tm_queue_mgr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tm_queue_mgr_tb \
	-f tm_queue_mgr.f -o sim_tm_queue_mgr || exit 1
out="$(./obj_dir/sim_tm_queue_mgr)"
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
